//--- rtl/isa_pkg.sv
package isa_pkg;

	// ************************************************************
	// instruction word layout.
	// ************************************************************

	localparam int WORD_BITS = 16;

	typedef logic [WORD_BITS-1:0] insn_word_t;

	typedef struct packed {
		logic [4:0] major; // control transfers all share one major opcode.
		logic [2:0] sub;
		logic [7:0] operand;
	} insn_fields_t;

	localparam logic [4:0] JUMP_PREFIX = 5'h1f;
	localparam logic [2:0] JUMP_SUB_DIRECT = 3'b010;
	localparam logic [2:0] JUMP_SUB_INDIRECT = 3'b011;
	localparam logic [2:0] JUMP_SUB_CALL = 3'b110;

	// ************************************************************
	// line geometry.
	// ************************************************************

	localparam int LINE_WORDS = 8;
	localparam int WORD_IDX_BITS = $clog2(LINE_WORDS); // word offset sits just above the byte bit.

	typedef insn_word_t [LINE_WORDS-1:0] line_t;

	function automatic logic is_jump_class(insn_word_t word);
		insn_fields_t f;
		f = insn_fields_t'(word);
		return (f.major == JUMP_PREFIX) &&
			(f.sub == JUMP_SUB_DIRECT || f.sub == JUMP_SUB_INDIRECT || f.sub == JUMP_SUB_CALL);
	endfunction

endpackage

//--- rtl/fetch_pkg.sv
package fetch_pkg;

	localparam int ADDR_BITS = 26;

	typedef logic [ADDR_BITS-1:0] fetch_addr_t; // byte address whose bit 0 is always clear.
	typedef logic [4:0] fifo_size_t; // 0 to 16 words.
	typedef logic [3:0] word_count_t; // 1 to 8 words.

	// ************************************************************
	// memory and core interfaces.
	// ************************************************************

	typedef struct packed {
		logic valid; // held until the ack pulse.
		fetch_addr_t addr;
	} mem_req_t;

	typedef struct packed {
		logic ack;
		isa_pkg::line_t line;
	} mem_rsp_t;

	typedef struct packed {
		logic valid; // single cycle pulse.
		logic [31:0] target;
	} jump_req_t;

	// words from the address up to the end of its line.
	function automatic word_count_t line_word_count(fetch_addr_t addr);
		word_count_t offset;
		offset = word_count_t'(addr[isa_pkg::WORD_IDX_BITS:1]);
		return word_count_t'(isa_pkg::LINE_WORDS) - offset;
	endfunction

	function automatic fetch_addr_t word_align(fetch_addr_t addr);
		return {addr[ADDR_BITS-1:1], 1'b0};
	endfunction

endpackage

//--- rtl/line_scanner.sv
`timescale 1ns/1ps

module line_scanner (
	input isa_pkg::line_t line,
	input fetch_pkg::word_count_t word_count,
	output logic jump_found
);
	import isa_pkg::*;

	logic [LINE_WORDS-1:0] decoded;
	logic [LINE_WORDS-1:0] in_window;
	int unsigned first_valid;

	// ************************************************************
	// decode every position, then keep only the valid window.
	// ************************************************************

	always_comb begin
		for (int i = 0; i < LINE_WORDS; i++) begin
			decoded[i] = is_jump_class(line[i]);
		end
	end

	// the fetch address points into the line, so the valid words
	// are the top ones.
	always_comb begin
		first_valid = LINE_WORDS - int'(word_count);
		for (int i = 0; i < LINE_WORDS; i++) begin
			in_window[i] = (i >= first_valid);
		end
	end

	assign jump_found = |(decoded & in_window);

endmodule

//--- rtl/jump_control.sv
`timescale 1ns/1ps

module jump_control (
	input logic main_clk,
	input logic rst,
	input fetch_pkg::jump_req_t jump,
	input logic ack,
	input logic requesting,
	input logic jump_found,
	output logic performing_jump,
	output fetch_pkg::fetch_addr_t jump_target,
	output logic waiting_for_jump
);
	import fetch_pkg::*;

	logic jump_pending; // set after the pulse and cleared by the redirect.
	fetch_addr_t saved_target;
	logic redirect;

	assign performing_jump = jump.valid | jump_pending;

	// the pulse cycle uses the live target, later cycles the saved one.
	assign jump_target = jump.valid ? word_align(jump.target[ADDR_BITS-1:0]) : saved_target;

	// a pending line must come back before the fetch can be redirected.
	assign redirect = performing_jump & (~requesting | ack);

	always_ff @(posedge main_clk) begin
		saved_target <= jump_target;
	end

	always_ff @(posedge main_clk) begin
		if (rst) begin
			jump_pending <= 1'b0;
			waiting_for_jump <= 1'b0;
		end else if (redirect) begin
			jump_pending <= 1'b0;
			waiting_for_jump <= 1'b0;
		end else begin
			jump_pending <= performing_jump;
			// an ack here belongs to a line without a jump.
			if (requesting && ack && jump_found) begin
				waiting_for_jump <= 1'b1;
			end
		end
	end

endmodule

//--- rtl/fetch_sequencer.sv
`timescale 1ns/1ps

module fetch_sequencer #(
	parameter int FIFO_DEPTH = 16,
	parameter fetch_pkg::fetch_addr_t RESET_ADDR = '0
) (
	input logic main_clk,
	input logic rst,
	output fetch_pkg::mem_req_t mem_req,
	input fetch_pkg::mem_rsp_t mem_rsp,
	input fetch_pkg::fifo_size_t fifo_size_after_read,
	output fetch_pkg::fifo_size_t fifo_size,
	input logic performing_jump,
	input fetch_pkg::fetch_addr_t jump_target,
	input logic waiting_for_jump,
	output fetch_pkg::word_count_t word_count
);
	import fetch_pkg::*;

	localparam int FILL_BITS = $bits(fifo_size_t) + 1;

	fetch_addr_t fetch_addr;
	logic requesting;
	fifo_size_t size_q;

	logic [FILL_BITS-1:0] fill_next; // occupancy once this line is written.
	logic has_room;
	fetch_addr_t next_line_addr;

	// ************************************************************
	// room test and sequential advance.
	// ************************************************************

	assign word_count = line_word_count(fetch_addr);

	always_comb begin
		fill_next = FILL_BITS'(fifo_size_after_read) + FILL_BITS'(word_count);
		has_room = (fill_next < FILL_BITS'(FIFO_DEPTH));
	end

	// the next fetch starts on the following line boundary.
	assign next_line_addr = fetch_addr + fetch_addr_t'({word_count, 1'b0});

	// ************************************************************
	// request level, address and size.
	// ************************************************************

	always_ff @(posedge main_clk) begin
		if (rst) begin
			requesting <= 1'b0;
			fetch_addr <= word_align(RESET_ADDR);
			size_q <= '0;
		end else begin
			size_q <= fifo_size_after_read;
			if (performing_jump) size_q <= '0; // the FIFO is flushed on a jump.

			if (requesting) begin
				if (mem_rsp.ack) begin
					if (performing_jump) begin
						// this line is dropped and the target goes out at once.
						fetch_addr <= jump_target;
					end else begin
						size_q <= fill_next[FILL_BITS-2:0];
						fetch_addr <= next_line_addr;
						requesting <= 1'b0;
					end
				end
			end else if (performing_jump) begin
				fetch_addr <= jump_target;
				requesting <= 1'b1;
			end else if (has_room && !waiting_for_jump) begin
				requesting <= 1'b1;
			end
		end
	end

	assign mem_req = '{valid: requesting, addr: fetch_addr};

	// nothing already counted survives a jump.
	assign fifo_size = performing_jump ? '0 : size_q;

endmodule

//--- rtl/fetch_top.sv
`timescale 1ns/1ps

module fetch_top #(
	parameter int FIFO_DEPTH = 16,
	parameter fetch_pkg::fetch_addr_t RESET_ADDR = '0
) (
	input logic main_clk,
	input logic rst,
	output fetch_pkg::mem_req_t mem_req,
	input fetch_pkg::mem_rsp_t mem_rsp,
	input fetch_pkg::fifo_size_t fifo_size_after_read,
	output fetch_pkg::fifo_size_t fifo_size,
	input fetch_pkg::jump_req_t jump,
	output logic performing_jump
);
	import fetch_pkg::*;

	word_count_t word_count;
	logic jump_found;
	fetch_addr_t jump_target;
	logic waiting_for_jump;

	fetch_sequencer #(
		.FIFO_DEPTH(FIFO_DEPTH),
		.RESET_ADDR(RESET_ADDR)
	) fetch_sequencer_inst (
		.main_clk(main_clk),
		.rst(rst),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp),
		.fifo_size_after_read(fifo_size_after_read),
		.fifo_size(fifo_size),
		.performing_jump(performing_jump),
		.jump_target(jump_target),
		.waiting_for_jump(waiting_for_jump),
		.word_count(word_count)
	);

	jump_control jump_control_inst (
		.main_clk(main_clk),
		.rst(rst),
		.jump(jump),
		.ack(mem_rsp.ack),
		.requesting(mem_req.valid),
		.jump_found(jump_found),
		.performing_jump(performing_jump),
		.jump_target(jump_target),
		.waiting_for_jump(waiting_for_jump)
	);

	line_scanner line_scanner_inst (
		.line(mem_rsp.line),
		.word_count(word_count),
		.jump_found(jump_found)
	);

endmodule

//--- test/fetch_props.sv
`timescale 1ns/1ps

module fetch_props (
	input logic main_clk,
	input logic rst,
	input fetch_pkg::mem_req_t mem_req,
	input fetch_pkg::mem_rsp_t mem_rsp,
	input logic performing_jump
);

	// ************************************************************
	// request protocol toward instruction memory.
	// ************************************************************

	// the address may only move once the memory has answered.
	addr_stable: assert property (@(posedge main_clk) disable iff (rst)
		mem_req.valid && !mem_rsp.ack |=> $stable(mem_req.addr))
		else $error("request address changed while waiting for the memory");

	valid_drops: assert property (@(posedge main_clk) disable iff (rst)
		mem_req.valid && mem_rsp.ack && !performing_jump |=> !mem_req.valid)
		else $error("request stayed up after an ack without a jump");

	word_aligned: assert property (@(posedge main_clk) disable iff (rst)
		!mem_req.addr[0])
		else $error("request address has bit 0 set");

endmodule

bind fetch_sequencer fetch_props props_inst (
	.main_clk(main_clk),
	.rst(rst),
	.mem_req(mem_req),
	.mem_rsp(mem_rsp),
	.performing_jump(performing_jump)
);

//--- test/tb_fetch.sv
`timescale 1ns/1ps

module tb_fetch;
	import isa_pkg::*;
	import fetch_pkg::*;

	localparam int TIMEOUT_MARGIN = 200;
	localparam int MEM_LINES = 64;

	logic main_clk = 1'b0;
	logic rst = 1'b1;
	mem_req_t mem_req;
	mem_rsp_t mem_rsp = '0;
	fifo_size_t fifo_size_after_read = '0;
	fifo_size_t fifo_size;
	jump_req_t jump = '0;
	logic performing_jump;

	line_t mem [MEM_LINES];
	int ack_delay = 0;
	logic rand_delay = 1'b0;
	int extra_delay = 0; // drawn at each ack and used by the next request.
	int wait_cnt = 0;

	string script [$];
	string test_name = "none";
	int cycle_limit = 0;
	int cycles = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int check_errors = 0;
	int test_errors = 0;
	logic load_ok = 1'b0;

	fetch_top fetch_top_inst (
		.main_clk(main_clk),
		.rst(rst),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp),
		.fifo_size_after_read(fifo_size_after_read),
		.fifo_size(fifo_size),
		.jump(jump),
		.performing_jump(performing_jump)
	);

	always #5 main_clk = ~main_clk;

	// ************************************************************
	// memory model and run limit.
	// ************************************************************

	initial begin
		void'($urandom(32'hf06e_e0d1));
		forever begin
			@(posedge main_clk);
			if (rst) begin
				mem_rsp <= '0;
				wait_cnt <= 0;
			end else if (mem_rsp.ack) begin
				mem_rsp.ack <= 1'b0;
			end else if (mem_req.valid) begin
				if (wait_cnt >= ack_delay + extra_delay) begin
					mem_rsp <= '{ack: 1'b1, line: mem[mem_req.addr[9:4]]};
					wait_cnt <= 0;
					extra_delay <= rand_delay ? int'($urandom_range(3, 0)) : 0;
				end else begin
					wait_cnt <= wait_cnt + 1;
				end
			end
		end
	end

	always @(posedge main_clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("timeout: the golden sequence did not finish within %0d cycles",
				cycle_limit);
			$display("Result: FAILED");
			$finish;
		end
	end

	// ************************************************************
	// compare tasks.
	// ************************************************************

	task automatic check_addr(string what, fetch_addr_t expected, fetch_addr_t actual);
		if (actual !== expected) begin
			$display("** Error %s %s: expected %h, actual %h", test_name, what, expected, actual);
			test_errors++;
		end
	endtask

	task automatic check_size(string what, fifo_size_t expected, fifo_size_t actual);
		if (actual !== expected) begin
			$display("** Error %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
			test_errors++;
		end
	endtask

	task automatic check_flag(string what, logic expected, logic actual);
		if (actual !== expected) begin
			$display("** Error %s %s: expected %b, actual %b", test_name, what, expected, actual);
			test_errors++;
		end
	endtask

	// inputs change on the edge and outputs are read 1 ns later.
	task automatic next_edge();
		@(posedge main_clk);
		jump.valid <= 1'b0; // the jump is a single cycle pulse.
	endtask

	task automatic step();
		next_edge();
		#1;
	endtask

	task automatic load_script();
		int fd;
		int len;
		int total;
		string text;
		string cmd;
		string name;
		total = 0;
		fd = $fopen("test/fetch_golden.txt", "r");
		if (fd != 0) begin
			while (!$feof(fd)) begin
				text = "";
				void'($fgets(text, fd));
				if (text.len() < 2 || text[0] == "#") continue;
				script.push_back(text);
				if ($sscanf(text, "%s %s %d", cmd, name, len) == 3 && cmd == "test") total += len;
			end
			$fclose(fd);
			cycle_limit = total + TIMEOUT_MARGIN;
			load_ok = 1'b1;
		end
	endtask

	task automatic run_line(string text);
		string cmd;
		string name;
		logic [31:0] arg0;
		logic [127:0] arg1;
		arg0 = '0;
		arg1 = '0;
		void'($sscanf(text, "%s %h %h", cmd, arg0, arg1));
		case (cmd)
			"test": begin
				void'($sscanf(text, "%s %s", cmd, name));
				test_name = name;
				test_errors = 0;
				tests_run++;
			end
			"end": begin
				if (test_errors == 0) begin
					$display("test %s: ok", test_name);
				end else begin
					$display("test %s: %0d errors", test_name, test_errors);
					tests_failed++;
				end
				check_errors += test_errors;
			end
			"mem": mem[arg0[5:0]] = arg1;
			"delay": ack_delay = int'(arg0);
			"rand": rand_delay = arg0[0];
			"fifo": begin
				next_edge();
				fifo_size_after_read <= arg0[4:0];
				#1;
			end
			"jump": begin
				next_edge();
				jump <= '{valid: 1'b1, target: arg0};
				#1;
			end
			"expect_req": begin
				while (!mem_req.valid) step();
				check_addr("request address", arg0[ADDR_BITS-1:0], mem_req.addr);
			end
			"expect_size": check_size("fifo_size", arg0[4:0], fifo_size);
			"expect_pj": check_flag("performing_jump", arg0[0], performing_jump);
			"expect_valid": check_flag("request valid", arg0[0], mem_req.valid);
			"wait_ack": begin
				while (!mem_rsp.ack) step();
				step();
			end
			"idle": repeat (int'(arg0)) step();
			"quiet": begin
				repeat (int'(arg0)) begin
					step();
					check_flag("request held off", 1'b0, mem_req.valid);
				end
			end
			default: begin
				$display("unknown command in golden file: %s", cmd);
				test_errors++;
			end
		endcase
	endtask

	// ************************************************************
	// main sequence.
	// ************************************************************

	initial begin
		// every default word has the jump major opcode with a non-jump sub-opcode.
		for (int i = 0; i < MEM_LINES; i++) begin
			for (int w = 0; w < LINE_WORDS; w++) begin
				mem[i][w] = {JUMP_PREFIX, 2'b00, 1'(w), 6'(i), 2'(w >> 1)};
			end
		end
		load_script();
		if (!load_ok) begin
			$display("could not open the golden file test/fetch_golden.txt");
			$display("Result: FAILED");
			$finish;
		end else begin
			repeat (8) @(posedge main_clk);
			rst <= 1'b0;
			#1;
			foreach (script[i]) run_line(script[i]);
			$display("tests: %0d run, %0d failed, %0d check errors",
				tests_run, tests_failed, check_errors);
			if (check_errors == 0 && tests_failed == 0 && tests_run > 0) begin
				$display("Result: PASSED");
			end else begin
				$display("Result: FAILED");
			end
			$finish;
		end
	end

endmodule

//--- test/fetch_golden.txt
# columns: command, then operands in hex (test lengths in decimal cycles)
# mem <line index> <line, word 7 first> | test <name> <cycles> | end | fifo | jump | delay | rand
mem 20 f1000000fa0000000000000000000000
mem 21 0000000000000000000000000000fe00
test reset 20
delay 0
expect_valid 0
expect_size 0
expect_pj 0
fifo 0
expect_req 0
wait_ack
expect_size 8
end
test sequential 30
fifo 3
expect_req 10
wait_ack
expect_size b
expect_req 20
fifo 8
wait_ack
expect_size 10
quiet 4
end
test unaligned 30
delay 2
jump 106
expect_pj 1
expect_size 0
fifo 2
expect_req 106
expect_pj 0
wait_ack
expect_size 7
expect_req 110
end
test pending_jump 30
jump 20c
expect_pj 1
expect_size 0
expect_valid 1
idle 1
expect_pj 1
wait_ack
expect_pj 0
expect_size 0
expect_req 20c
end
test scan_window 50
wait_ack
expect_size 4
expect_req 210
wait_ack
expect_size a
quiet 6
jump 300
expect_req 300
end
test back_pressure 60
rand 1
fifo 9
wait_ack
expect_size 11
quiet 5
fifo 7
expect_req 310
fifo 8
wait_ack
expect_size 10
quiet 5
fifo 0
expect_req 320
wait_ack
expect_size 8
end

//--- run.sh
#!/usr/bin/env bash
# compile and run the fetch testbench with Verilator.
cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert -f flist.f --top-module tb_fetch -o tb_fetch \
	&& ./obj_dir/tb_fetch | tee sim.log \
	|| { echo "build or run failed"; exit 1; }

grep -qx "Result: PASSED" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- flist.f
rtl/isa_pkg.sv
rtl/fetch_pkg.sv
rtl/line_scanner.sv
rtl/jump_control.sv
rtl/fetch_sequencer.sv
rtl/fetch_top.sv
test/fetch_props.sv
test/tb_fetch.sv
